// File: logic/cmd_format_pkg.sv
/*
 * Command format definitions
 * Queue slot layout, command type codes and the command length rule
 */

`default_nettype none

package cmd_format_pkg;

    // Valid flag is the low bit of byte 7 of every slot
    localparam int entry_valid_bit = 56;
    localparam logic [7:0] valid_byte_we = 8'h80;

    // Header fields
    localparam int cmd_type_lsb = 0;
    localparam int cmd_type_width = 4;
    localparam int num_args_lsb = 8;
    localparam int num_args_width = 4;

    localparam logic [3:0] exec_task_code = 4'd1;
    localparam logic [3:0] setup_inst_code = 4'd2;
    localparam logic [3:0] periodic_task_code = 4'd5;

    typedef logic [5:0] cmd_len_t; // Up to 4 + 2*15 words

    // Total words of a command, header included
    function automatic cmd_len_t cmd_words(
        input logic [cmd_type_width-1:0] code,
        input logic [num_args_width-1:0] nargs
    );
        cmd_len_t arg_words;
        arg_words = {1'b0, nargs, 1'b0}; // Two words per argument
        if (code == setup_inst_code) begin
            return 6'd2;
        end else if (code == exec_task_code) begin
            return 6'd3 + arg_words;
        end
        return 6'd4 + arg_words; // Periodic, and any unknown code
    endfunction

endpackage

`default_nettype wire

// File: logic/dispatch_pkg.sv
/*
 * Dispatcher definitions
 * Queue RAM word types and the stream FSM state encoding
 */

`default_nettype none

package dispatch_pkg;

    typedef logic [63:0] word_t;
    typedef logic [7:0] byte_we_t;

    localparam int ram_addr_width = 32; // Byte address toward the queue RAM

    typedef enum logic [2:0] {
        scan,
        issue_read,
        check_header,
        send,
        fetch_next,
        commit
    } stream_state_t;

endpackage

`default_nettype wire

// File: logic/acc_slot_table.sv
/*
 * Accelerator slot table
 * Availability bits, subqueue read indices and the round-robin pointer
 */

`timescale 1ns/1ps
`default_nettype none

module acc_slot_table #(
    parameter int max_accs = 16,
    parameter int subqueue_bits = 6,
    parameter int acc_bits = 4
) (
    input  logic clk,
    input  logic rstn,
    input  logic acc_avail_wr,
    input  logic [acc_bits-1:0] acc_avail_wr_address,
    input  logic scan_next,
    input  logic commit,
    input  logic [subqueue_bits-1:0] commit_idx,
    input  logic commit_busy,
    output logic [acc_bits-1:0] cand_acc,
    output logic [subqueue_bits-1:0] cand_idx,
    output logic cand_ready
);

    localparam logic [acc_bits-1:0] last_acc = acc_bits'(max_accs - 1);

    logic [max_accs-1:0] acc_avail;
    logic [subqueue_bits-1:0] read_idx [max_accs];
    logic [acc_bits-1:0] rr_ptr;
    logic [acc_bits-1:0] rr_ptr_next;

    // Wrap explicitly so non power of two counts work
    always_comb begin
        if (rr_ptr == last_acc) begin
            rr_ptr_next = '0;
        end else begin
            rr_ptr_next = rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            acc_avail <= {max_accs{1'b1}};
            rr_ptr <= '0;
            for (int i = 0; i < max_accs; i++) begin
                read_idx[i] <= '0;
            end
        end else begin
            if (commit) begin
                read_idx[rr_ptr] <= commit_idx;
                if (commit_busy) begin
                    acc_avail[rr_ptr] <= 1'b0;
                end
            end
            // Availability pulse overrides a busy mark on the same edge
            if (acc_avail_wr) begin
                acc_avail[acc_avail_wr_address] <= 1'b1;
            end
            if (scan_next || commit) begin
                rr_ptr <= rr_ptr_next;
            end
        end
    end

    assign cand_acc = rr_ptr;
    assign cand_idx = read_idx[rr_ptr];
    assign cand_ready = acc_avail[rr_ptr];

endmodule

`default_nettype wire

// File: logic/cmd_stream_fsm.sv
/*
 * Command stream FSM
 * Reads a command from the queue RAM, streams it to its accelerator
 * and clears the valid byte of every slot that was sent
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_stream_fsm #(
    parameter int subqueue_bits = 6,
    parameter int acc_bits = 4
) (
    input  logic clk,
    input  logic rstn,
    // Candidate from the slot table
    input  logic [acc_bits-1:0] cand_acc,
    input  logic [subqueue_bits-1:0] cand_idx,
    input  logic cand_ready,
    output logic scan_next,
    output logic commit,
    output logic [subqueue_bits-1:0] commit_idx,
    output logic commit_busy,
    // Queue RAM side
    output logic [acc_bits-1:0] ram_acc,
    output logic [subqueue_bits-1:0] ram_idx,
    output logic ram_en,
    output dispatch_pkg::byte_we_t ram_we,
    output dispatch_pkg::word_t ram_din,
    input  dispatch_pkg::word_t ram_dout,
    // Output word stream
    output dispatch_pkg::word_t out_tdata,
    output logic out_tvalid,
    input  logic out_tready,
    output logic [acc_bits-1:0] out_tdest,
    output logic out_tlast
);

    dispatch_pkg::stream_state_t state;

    logic [acc_bits-1:0] acc_id;
    logic [subqueue_bits-1:0] slot_idx;
    cmd_format_pkg::cmd_len_t words_left; // Words after the current one
    logic is_setup;

    logic [cmd_format_pkg::cmd_type_width-1:0] hdr_type;
    logic [cmd_format_pkg::num_args_width-1:0] hdr_args;
    logic hdr_valid;
    logic xfer;

    assign hdr_type = ram_dout[cmd_format_pkg::cmd_type_lsb +: cmd_format_pkg::cmd_type_width];
    assign hdr_args = ram_dout[cmd_format_pkg::num_args_lsb +: cmd_format_pkg::num_args_width];
    assign hdr_valid = ram_dout[cmd_format_pkg::entry_valid_bit];

    assign xfer = out_tvalid && out_tready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= dispatch_pkg::scan;
        end else begin
            case (state)
                dispatch_pkg::scan: begin
                    if (cand_ready) begin
                        state <= dispatch_pkg::issue_read;
                    end
                end

                dispatch_pkg::issue_read: begin
                    state <= dispatch_pkg::check_header;
                end

                dispatch_pkg::check_header: begin
                    if (hdr_valid) begin
                        state <= dispatch_pkg::send;
                    end else begin
                        state <= dispatch_pkg::scan; // Empty front, try the next one
                    end
                end

                dispatch_pkg::send: begin
                    if (xfer) begin
                        if (words_left == '0) begin
                            state <= dispatch_pkg::commit;
                        end else begin
                            state <= dispatch_pkg::fetch_next;
                        end
                    end
                end

                dispatch_pkg::fetch_next: begin
                    state <= dispatch_pkg::send;
                end

                default: begin
                    state <= dispatch_pkg::scan;
                end
            endcase
        end
    end

    // Command context
    always_ff @(posedge clk) begin
        if (state == dispatch_pkg::scan) begin
            acc_id <= cand_acc;
            slot_idx <= cand_idx;
        end
        if (state == dispatch_pkg::check_header) begin
            words_left <= cmd_format_pkg::cmd_words(hdr_type, hdr_args) - 6'd1;
            is_setup <= (hdr_type == cmd_format_pkg::setup_inst_code);
        end
        if (state == dispatch_pkg::send && xfer) begin
            words_left <= words_left - 6'd1;
            slot_idx <= slot_idx + 1'b1; // Wraps at the subqueue end
        end
    end

    always_comb begin
        ram_en = 1'b0;
        ram_we = '0;
        case (state)
            dispatch_pkg::issue_read: ram_en = 1'b1;
            dispatch_pkg::fetch_next: ram_en = 1'b1;
            dispatch_pkg::send: begin
                ram_en = 1'b1; // Rereads the same slot while waiting
                if (out_tready) begin
                    ram_we = cmd_format_pkg::valid_byte_we;
                end
            end
            default: ram_en = 1'b0;
        endcase
    end

    assign ram_acc = acc_id;
    assign ram_idx = slot_idx;
    assign ram_din = '0; // Only the valid byte is enabled

    assign scan_next = (state == dispatch_pkg::scan && !cand_ready) ||
                       (state == dispatch_pkg::check_header && !hdr_valid);

    assign commit = (state == dispatch_pkg::commit);
    assign commit_idx = slot_idx;
    assign commit_busy = !is_setup; // Setup leaves the accelerator free

    assign out_tdata = ram_dout;
    assign out_tvalid = (state == dispatch_pkg::send);
    assign out_tdest = acc_id;
    assign out_tlast = (words_left == '0);

endmodule

`default_nettype wire

// File: logic/cmd_in_top.sv
/*
 * Command dispatcher top level
 * Joins the slot table to the stream FSM and forms the queue RAM address
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_in_top #(
    parameter int max_accs = 16,
    parameter int subqueue_bits = 6,
    localparam int acc_bits = $clog2(max_accs)
) (
    input  logic clk,
    input  logic rstn,
    // Queue RAM
    output logic [dispatch_pkg::ram_addr_width-1:0] cmdin_queue_addr,
    output logic cmdin_queue_en,
    output dispatch_pkg::byte_we_t cmdin_queue_we,
    output dispatch_pkg::word_t cmdin_queue_din,
    input  dispatch_pkg::word_t cmdin_queue_dout,
    // Stream toward the accelerators
    output dispatch_pkg::word_t out_tdata,
    output logic out_tvalid,
    input  logic out_tready,
    output logic [acc_bits-1:0] out_tdest,
    output logic out_tlast,
    // Availability writes
    input  logic acc_avail_wr,
    input  logic [acc_bits-1:0] acc_avail_wr_address
);

    localparam int addr_pad = dispatch_pkg::ram_addr_width - acc_bits - subqueue_bits - 3;

    logic [acc_bits-1:0] cand_acc;
    logic [subqueue_bits-1:0] cand_idx;
    logic cand_ready;
    logic scan_next;
    logic commit;
    logic [subqueue_bits-1:0] commit_idx;
    logic commit_busy;
    logic [acc_bits-1:0] ram_acc;
    logic [subqueue_bits-1:0] ram_idx;

    acc_slot_table #(
        .max_accs(max_accs),
        .subqueue_bits(subqueue_bits),
        .acc_bits(acc_bits)
    ) acc_slot_table_inst (
        .clk(clk),
        .rstn(rstn),
        .acc_avail_wr(acc_avail_wr),
        .acc_avail_wr_address(acc_avail_wr_address),
        .scan_next(scan_next),
        .commit(commit),
        .commit_idx(commit_idx),
        .commit_busy(commit_busy),
        .cand_acc(cand_acc),
        .cand_idx(cand_idx),
        .cand_ready(cand_ready)
    );

    cmd_stream_fsm #(
        .subqueue_bits(subqueue_bits),
        .acc_bits(acc_bits)
    ) cmd_stream_fsm_inst (
        .clk(clk),
        .rstn(rstn),
        .cand_acc(cand_acc),
        .cand_idx(cand_idx),
        .cand_ready(cand_ready),
        .scan_next(scan_next),
        .commit(commit),
        .commit_idx(commit_idx),
        .commit_busy(commit_busy),
        .ram_acc(ram_acc),
        .ram_idx(ram_idx),
        .ram_en(cmdin_queue_en),
        .ram_we(cmdin_queue_we),
        .ram_din(cmdin_queue_din),
        .ram_dout(cmdin_queue_dout),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tdest(out_tdest),
        .out_tlast(out_tlast)
    );

    // Accelerator id selects the subqueue, 8 bytes per slot
    assign cmdin_queue_addr = {{addr_pad{1'b0}}, ram_acc, ram_idx, 3'b000};

endmodule

`default_nettype wire

// File: tests/cmd_queue_model.sv
/*
 * Queue RAM model
 * Single-port word RAM with byte write enables and one-cycle read latency
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_queue_model #(
    parameter int depth = 64,
    parameter int addr_width = 32
) (
    input  logic clk,
    input  logic [addr_width-1:0] addr,
    input  logic en,
    input  dispatch_pkg::byte_we_t we,
    input  dispatch_pkg::word_t din,
    output dispatch_pkg::word_t dout
);

    localparam int index_bits = $clog2(depth);

    dispatch_pkg::word_t mem [depth];

    logic [index_bits-1:0] index;

    assign index = addr[index_bits+2:3]; // 8 bytes per word

    // Fill pattern follows the whole word index, valid byte left clear
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = {8'h00, 24'(i * 24'h010101), ~32'(i)};
        end
        dout = '0;
    end

    // Read before write on the same address
    always @(posedge clk) begin
        if (en) begin
            dout <= mem[index];
            for (int b = 0; b < 8; b++) begin
                if (we[b]) begin
                    mem[index][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/cmd_in_tb.sv
/*
 * Command dispatcher testbench
 * Preloads queue commands, drives random back-pressure and checks every streamed word
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_in_tb;

    localparam int max_accs = 4;
    localparam int subqueue_bits = 4;
    localparam int slots = 1 << subqueue_bits;
    localparam int cycle_limit = 4000;

    logic clk = 1'b0;
    logic rstn;
    logic [31:0] cmdin_queue_addr;
    logic cmdin_queue_en;
    dispatch_pkg::byte_we_t cmdin_queue_we;
    dispatch_pkg::word_t cmdin_queue_din;
    dispatch_pkg::word_t cmdin_queue_dout;
    dispatch_pkg::word_t out_tdata;
    logic out_tvalid;
    logic out_tready;
    logic [1:0] out_tdest;
    logic out_tlast;
    logic acc_avail_wr;
    logic [1:0] acc_avail_wr_address;

    integer seed = 32'hc718a66b;
    int error_count = 0;
    int word_count = 0;
    int cycles = 0;
    logic in_cmd = 1'b0;
    logic [1:0] cur_dest = '0;

    dispatch_pkg::word_t exp_data [max_accs][$];
    logic exp_last [max_accs][$];
    dispatch_pkg::word_t shadow [max_accs*slots];
    int loaded [$];

    cmd_in_top #(
        .max_accs(max_accs),
        .subqueue_bits(subqueue_bits)
    ) cmd_in_top_inst (
        .clk(clk),
        .rstn(rstn),
        .cmdin_queue_addr(cmdin_queue_addr),
        .cmdin_queue_en(cmdin_queue_en),
        .cmdin_queue_we(cmdin_queue_we),
        .cmdin_queue_din(cmdin_queue_din),
        .cmdin_queue_dout(cmdin_queue_dout),
        .out_tdata(out_tdata),
        .out_tvalid(out_tvalid),
        .out_tready(out_tready),
        .out_tdest(out_tdest),
        .out_tlast(out_tlast),
        .acc_avail_wr(acc_avail_wr),
        .acc_avail_wr_address(acc_avail_wr_address)
    );

    cmd_queue_model #(
        .depth(max_accs * slots),
        .addr_width(32)
    ) queue_ram_inst (
        .clk(clk),
        .addr(cmdin_queue_addr),
        .en(cmdin_queue_en),
        .we(cmdin_queue_we),
        .din(cmdin_queue_din),
        .dout(cmdin_queue_dout)
    );

    always #50 clk = ~clk;

    // Command length from the header fields
    function automatic int expected_len(input logic [3:0] code, input logic [3:0] nargs);
        if (code == cmd_format_pkg::setup_inst_code) begin
            return 2;
        end
        if (code == cmd_format_pkg::exec_task_code) begin
            return 3 + 2 * int'(nargs);
        end
        return 4 + 2 * int'(nargs); // Periodic
    endfunction

    // Writes a command into the RAM and queues the words the DUT should send
    task automatic load_command(input int acc, input int start, input logic [3:0] code,
                                input logic [3:0] nargs);
        int n;
        int addr;
        dispatch_pkg::word_t w;
        n = expected_len(code, nargs);
        for (int i = 0; i < n; i++) begin
            addr = acc * slots + (start + i) % slots;
            w = {8'h01, 8'(acc), 16'(start), 32'(i) ^ 32'h5a5a0000};
            if (i == 0) begin
                w[3:0] = code;
                w[11:8] = nargs;
            end
            queue_ram_inst.mem[addr] = w;
            shadow[addr] = w;
            loaded.push_back(addr);
            exp_data[acc].push_back(w);
            exp_last[acc].push_back(i == n - 1);
        end
    endtask

    task automatic wait_words_left(input int acc, input int left);
        while (exp_data[acc].size() > left) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_avail(input int acc);
        @(posedge clk);
        acc_avail_wr <= 1'b1;
        acc_avail_wr_address <= 2'(acc);
        @(posedge clk);
        acc_avail_wr <= 1'b0;
    endtask

    // Sent slots keep every byte except a cleared valid byte
    task automatic check_cleared();
        dispatch_pkg::word_t want;
        foreach (loaded[i]) begin
            want = {8'h00, shadow[loaded[i]][55:0]};
            assert (queue_ram_inst.mem[loaded[i]] == want) else begin
                error_count++;
                $display("[ERROR] %0t: slot %0d reads %h, expected %h", $time, loaded[i],
                         queue_ram_inst.mem[loaded[i]], want);
            end
        end
        loaded.delete();
    endtask

    always @(posedge clk) begin
        out_tready <= $random(seed);
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Timeout: the expected words did not all arrive within %0d cycles",
                     cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // Comparison of every accepted word
    always @(posedge clk) begin
        if (rstn && out_tvalid && out_tready) begin
            word_count++;
            if (in_cmd) begin
                assert (out_tdest == cur_dest) else begin
                    error_count++;
                    $display("[ERROR] %0t: dest %0d interleaved into command for %0d",
                             $time, out_tdest, cur_dest);
                end
            end
            cur_dest = out_tdest;
            in_cmd = !out_tlast;
            assert (exp_data[out_tdest].size() > 0) else begin
                error_count++;
                $display("[ERROR] %0t: unexpected word %h for dest %0d", $time,
                         out_tdata, out_tdest);
            end
            if (exp_data[out_tdest].size() > 0) begin
                assert (out_tdata == exp_data[out_tdest][0]) else begin
                    error_count++;
                    $display("[ERROR] %0t: dest %0d data %h, expected %h", $time,
                             out_tdest, out_tdata, exp_data[out_tdest][0]);
                end
                assert (out_tlast == exp_last[out_tdest][0]) else begin
                    error_count++;
                    $display("[ERROR] %0t: dest %0d last %b, expected %b", $time,
                             out_tdest, out_tlast, exp_last[out_tdest][0]);
                end
                void'(exp_data[out_tdest].pop_front());
                void'(exp_last[out_tdest].pop_front());
            end
        end
    end

    initial begin
        rstn = 1'b0;
        out_tready = 1'b0;
        acc_avail_wr = 1'b0;
        acc_avail_wr_address = '0;

        // Commands go in after the model has laid down its fill pattern
        @(posedge clk);
        load_command(1, 0, cmd_format_pkg::exec_task_code, 4'd2);
        load_command(0, 0, cmd_format_pkg::setup_inst_code, 4'd0);
        load_command(0, 2, cmd_format_pkg::exec_task_code, 4'd1); // No pulse needed
        load_command(2, 0, cmd_format_pkg::exec_task_code, 4'd0);
        load_command(2, 3, cmd_format_pkg::periodic_task_code, 4'd1);
        load_command(3, 0, cmd_format_pkg::exec_task_code, 4'd5);

        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        wait_words_left(0, 0);
        wait_words_left(1, 0);
        wait_words_left(3, 0);
        wait_words_left(2, 6);
        repeat (40) @(posedge clk);
        assert (exp_data[2].size() == 6) else begin
            error_count++;
            $display("[ERROR] %0t: accelerator 2 sent while busy", $time);
        end
        pulse_avail(2);
        wait_words_left(2, 0);
        repeat (4) @(posedge clk);
        check_cleared();

        // Periodic command across the end of subqueue 3
        load_command(3, 13, cmd_format_pkg::periodic_task_code, 4'd2);
        pulse_avail(3);
        wait_words_left(3, 0);
        repeat (4) @(posedge clk);
        check_cleared();

        $display("Words checked: %0d, errors: %0d", word_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/cmd_format_pkg.sv
logic/dispatch_pkg.sv
logic/acc_slot_table.sv
logic/cmd_stream_fsm.sv
logic/cmd_in_top.sv
tests/cmd_queue_model.sv
tests/cmd_in_tb.sv

// File: Bender.yml
package:
  name: cmd_in

sources:
  - logic/cmd_format_pkg.sv
  - logic/dispatch_pkg.sv
  - logic/acc_slot_table.sv
  - logic/cmd_stream_fsm.sv
  - logic/cmd_in_top.sv
  - target: test
    files:
      - tests/cmd_queue_model.sv
      - tests/cmd_in_tb.sv
